/* project.f */
hw/cpuPkg.sv
hw/controlUnit.sv
hw/regFile.sv
hw/decode.sv
hw/execute.sv
hw/result.sv
hw/cpuCore.sv
dv/cpuCoreTb.sv

/* Makefile */
# Verilator build and run of the core testbench
TOP = cpuCoreTb

all: run

run:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o simv
	./obj_dir/simv | awk '{ print } /^test passed$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* dv/cpuCoreTb.sv */
`default_nettype none

module cpuCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cpuPkg::*;

    localparam logic [15:0] NopWord = {opNop, 11'b0};

    typedef struct packed {
        logic [15:0] pc;
        logic [15:0] instr;
        logic        wbEn;
        logic [2:0]  wbReg;
        logic [15:0] wbData;
        logic        halt;
        logic        err;
    } stepT;

    logic        clk;
    logic        rst;
    logic [15:0] instr;
    logic [15:0] pc;
    logic        wbEn;
    logic [2:0]  wbReg;
    logic [15:0] wbData;
    logic        halt;
    logic        err;

    stepT steps[$];
    logic programReady = 1'b0;
    int   checks = 0;
    int   errors = 0;

    cpuCore #(
        .DataWords (256),
        .ResetPc   (16'h0000)
    ) cpuCore_i (
        .clk    (clk),
        .rst    (rst),
        .instr  (instr),
        .pc     (pc),
        .wbEn   (wbEn),
        .wbReg  (wbReg),
        .wbData (wbData),
        .halt   (halt),
        .err    (err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encoding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [15:0] encI(input logic [4:0] op, input logic [2:0] rs,
                                         input logic [2:0] rd, input logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic logic [15:0] encR(input logic [4:0] op, input logic [2:0] rs,
                                         input logic [2:0] rt, input logic [2:0] rd,
                                         input logic [1:0] func);
        return {op, rs, rt, rd, func};
    endfunction

    function automatic logic [15:0] encL(input logic [4:0] op, input logic [2:0] rs,
                                         input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic logic [15:0] encJ(input logic [4:0] op, input logic [10:0] offset);
        return {op, offset};
    endfunction

    function automatic logic [15:0] signExtend5(input logic [4:0] v);
        return {{11{v[4]}}, v};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic addStep(input logic [15:0] pcVal, input logic [15:0] word,
                           input logic wbEnExp, input logic [2:0] wbRegExp,
                           input logic [15:0] wbDataExp, input logic haltExp,
                           input logic errExp);
        stepT s;
        s.pc     = pcVal;
        s.instr  = word;
        s.wbEn   = wbEnExp;
        s.wbReg  = wbRegExp;
        s.wbData = wbDataExp;
        s.halt   = haltExp;
        s.err    = errExp;
        steps.push_back(s);
    endtask

    task automatic addWrite(input logic [15:0] pcVal, input logic [15:0] word,
                            input logic [2:0] regIdx, input logic [15:0] data);
        addStep(pcVal, word, 1'b1, regIdx, data, 1'b0, 1'b0);
    endtask

    task automatic addQuiet(input logic [15:0] pcVal, input logic [15:0] word,
                            input logic haltExp, input logic errExp);
        addStep(pcVal, word, 1'b0, 3'd0, 16'h0000, haltExp, errExp);
    endtask

    task automatic buildProgram();
        int          seed;
        logic [31:0] rnd;
        logic [15:0] a;
        logic [15:0] b;
        seed = 76429;
        rnd  = $random(seed);
        a    = rnd[15:0];
        rnd  = $random(seed);
        b    = rnd[15:0];

        // r1 and r2 get a and b one byte at a time
        addWrite(16'd0, encL(opLbi, 3'd1, a[15:8]), 3'd1, {{8{a[15]}}, a[15:8]});
        addWrite(16'd2, encL(opSlbi, 3'd1, a[7:0]), 3'd1, a);
        addWrite(16'd4, encL(opLbi, 3'd2, b[15:8]), 3'd2, {{8{b[15]}}, b[15:8]});
        addWrite(16'd6, encL(opSlbi, 3'd2, b[7:0]), 3'd2, b);
        addWrite(16'd8, encR(opAlu, 3'd1, 3'd2, 3'd3, 2'b00), 3'd3, a + b);
        addWrite(16'd10, encR(opAlu, 3'd1, 3'd2, 3'd4, 2'b01), 3'd4, a - b);
        addWrite(16'd12, encR(opAlu, 3'd1, 3'd2, 3'd5, 2'b10), 3'd5, a ^ b);
        addWrite(16'd14, encR(opAlu, 3'd1, 3'd2, 3'd6, 2'b11), 3'd6, a & ~b);
        // arithmetic sign-extends imm5 while logic ops zero-extend it
        addWrite(16'd16, encI(opAddi, 3'd1, 3'd3, 5'b10110), 3'd3, a + signExtend5(5'b10110));
        addWrite(16'd18, encI(opSubi, 3'd2, 3'd4, 5'b00111), 3'd4, b - 16'd7);
        addWrite(16'd20, encI(opXori, 3'd1, 3'd5, 5'b11001), 3'd5, a ^ 16'h0019);
        addWrite(16'd22, encI(opAndni, 3'd2, 3'd6, 5'b10101), 3'd6, b & ~16'h0015);
        addWrite(16'd24, encR(opSeq, 3'd1, 3'd1, 3'd3, 2'b00), 3'd3, 16'd1);
        addWrite(16'd26, encR(opSeq, 3'd1, 3'd2, 3'd4, 2'b00), 3'd4,
                 (a == b) ? 16'd1 : 16'd0);
        addWrite(16'd28, encR(opSlt, 3'd1, 3'd2, 3'd5, 2'b00), 3'd5,
                 ($signed(a) < $signed(b)) ? 16'd1 : 16'd0);
        addWrite(16'd30, encR(opSlt, 3'd2, 3'd1, 3'd6, 2'b00), 3'd6,
                 ($signed(b) < $signed(a)) ? 16'd1 : 16'd0);
        // r0 stays zero and serves as the base register
        addQuiet(16'd32, encI(opSt, 3'd0, 3'd1, 5'd5), 1'b0, 1'b0);
        addWrite(16'd34, encI(opLd, 3'd0, 3'd7, 5'd5), 3'd7, a);
        addQuiet(16'd36, encL(opBeqz, 3'd0, 8'd4), 1'b0, 1'b0);
        addQuiet(16'd42, encL(opBeqz, 3'd3, 8'd8), 1'b0, 1'b0);
        addQuiet(16'd44, encL(opBnez, 3'd3, 8'd6), 1'b0, 1'b0);
        addQuiet(16'd52, encL(opBnez, 3'd0, 8'h10), 1'b0, 1'b0);
        addWrite(16'd54, encJ(opJal, 11'd10), 3'd7, 16'd56);
        addWrite(16'd66, encL(opLbi, 3'd2, 8'h50), 3'd2, 16'h0050);
        addQuiet(16'd68, encL(opJr, 3'd2, 8'hFC), 1'b0, 1'b0);
        // backward jump lands on the illegal opcode
        addQuiet(16'd76, encJ(opJ, 11'h7F8), 1'b0, 1'b0);
        addQuiet(16'd70, {5'b11111, 11'h123}, 1'b0, 1'b1);
        addQuiet(16'd72, encI(opHalt, 3'd0, 3'd0, 5'd0), 1'b1, 1'b0);
        addQuiet(16'd72, encI(opHalt, 3'd0, 3'd0, 5'd0), 1'b1, 1'b0);
        addQuiet(16'd72, encI(opHalt, 3'd0, 3'd0, 5'd0), 1'b1, 1'b0);
    endtask

    // instruction memory made from the words of the program table
    function automatic logic [15:0] fetchWord(input logic [15:0] addr);
        logic [15:0] word;
        word = NopWord;
        foreach (steps[k]) begin
            if (steps[k].pc == addr) begin
                word = steps[k].instr;
            end
        end
        return word;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error at %0d ns: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic checkStep(input stepT s);
        checkValue("pc", pc, s.pc);
        checkValue("wbEn", {15'b0, wbEn}, {15'b0, s.wbEn});
        if (s.wbEn) begin
            checkValue("wbReg", {13'b0, wbReg}, {13'b0, s.wbReg});
            checkValue("wbData", wbData, s.wbData);
        end
        checkValue("halt", {15'b0, halt}, {15'b0, s.halt});
        checkValue("err", {15'b0, err}, {15'b0, s.err});
    endtask

    initial begin
        rst   = 1'b1;
        instr = NopWord;
        buildProgram();
        programReady = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (steps[k]) begin
            instr = fetchWord(pc);
            // sample just before the rising edge
            #4;
            checkStep(steps[k]);
            @(negedge clk);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (programReady);
        limit = (steps.size() + 10) * 10;
        #(limit);
        $display("timeout: the program table did not complete within %0d ns", limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cpuCore.sv */
`default_nettype none

module cpuCore #(
    parameter int          DataWords = 256,
    parameter logic [15:0] ResetPc   = 16'h0000
) (
    input  wire         clk,
    input  wire         rst,
    input  wire  [15:0] instr,
    output logic [15:0] pc,
    output logic        wbEn,
    output logic [2:0]  wbReg,
    output logic [15:0] wbData,
    output logic        halt,
    output logic        err
);
    import cpuPkg::*;

    aluOpT       aluOp;
    logic [15:0] pcPlus2;
    logic [15:0] nextPc;
    logic [15:0] aluOp1;
    logic [15:0] aluOp2;
    logic [15:0] immediate;
    logic [15:0] storeData;
    logic [15:0] aluOut;
    logic [15:0] writeData;
    logic        aluSrc;
    logic        branch;
    logic        branchOnZero;
    logic        jump;
    logic        jumpReg;
    logic        memWrite;
    logic        memRead;
    logic        memToReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= ResetPc;
        end else begin
            pc <= nextPc;
        end
    end

    assign pcPlus2 = pc + 16'd2;

    decode decode_i (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .writeData    (writeData),
        .pcPlus2      (pcPlus2),
        .aluOp1       (aluOp1),
        .aluOp2       (aluOp2),
        .immediate    (immediate),
        .storeData    (storeData),
        .wbEn         (wbEn),
        .wbReg        (wbReg),
        .wbValue      (wbData),
        .aluOp        (aluOp),
        .aluSrc       (aluSrc),
        .branch       (branch),
        .branchOnZero (branchOnZero),
        .jump         (jump),
        .jumpReg      (jumpReg),
        .memWrite     (memWrite),
        .memRead      (memRead),
        .memToReg     (memToReg),
        .halt         (halt),
        .err          (err)
    );

    execute execute_i (
        .aluOp1       (aluOp1),
        .aluOp2       (aluOp2),
        .immediate    (immediate),
        .pc           (pc),
        .pcPlus2      (pcPlus2),
        .aluOp        (aluOp),
        .aluSrc       (aluSrc),
        .branch       (branch),
        .branchOnZero (branchOnZero),
        .jump         (jump),
        .jumpReg      (jumpReg),
        .halt         (halt),
        .aluOut       (aluOut),
        .nextPc       (nextPc)
    );

    result #(
        .DataWords (DataWords)
    ) result_i (
        .clk       (clk),
        .rst       (rst),
        .aluOut    (aluOut),
        .storeData (storeData),
        .memWrite  (memWrite),
        .memRead   (memRead),
        .memToReg  (memToReg),
        .halt      (halt),
        .writeData (writeData)
    );

endmodule

`default_nettype wire

/* hw/result.sv */
`default_nettype none

module result #(
    parameter int DataWords = 256
) (
    input  wire         clk,
    input  wire         rst,
    input  wire  [15:0] aluOut,
    input  wire  [15:0] storeData,
    input  wire         memWrite,
    input  wire         memRead,
    input  wire         memToReg,
    input  wire         halt,
    output logic [15:0] writeData
);

    localparam int AddrBits = $clog2(DataWords);

    logic [15:0]         mem [DataWords];
    logic [AddrBits-1:0] addr;
    logic [15:0]         readData;

    // word addressed
    assign addr = aluOut[AddrBits-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DataWords; i++) begin
                mem[i] <= '0;
            end
        end else if (memWrite && !halt) begin
            mem[addr] <= storeData;
        end
    end

    assign readData  = memRead ? mem[addr] : 16'h0000;
    assign writeData = memToReg ? readData : aluOut;

endmodule

`default_nettype wire

/* hw/execute.sv */
`default_nettype none

module execute (
    input  wire [15:0]         aluOp1,
    input  wire [15:0]         aluOp2,
    input  wire [15:0]         immediate,
    input  wire [15:0]         pc,
    input  wire [15:0]         pcPlus2,
    input  wire cpuPkg::aluOpT aluOp,
    input  wire                aluSrc,
    input  wire                branch,
    input  wire                branchOnZero,
    input  wire                jump,
    input  wire                jumpReg,
    input  wire                halt,
    output logic [15:0]        aluOut,
    output logic [15:0]        nextPc
);
    import cpuPkg::*;

    logic [15:0] opB;
    logic        isZero;
    logic        taken;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign opB = aluSrc ? immediate : aluOp2;

    always_comb begin
        case (aluOp)
            aluAdd:   aluOut = aluOp1 + opB;
            aluSub:   aluOut = aluOp1 - opB;
            aluXor:   aluOut = aluOp1 ^ opB;
            aluAndn:  aluOut = aluOp1 & ~opB;
            aluPassB: aluOut = opB;
            aluSeq:   aluOut = {15'b0, aluOp1 == opB};
            // signed compare
            aluSlt:   aluOut = {15'b0, $signed(aluOp1) < $signed(opB)};
            default:  aluOut = 16'h0000;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next pc
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign isZero = (aluOp1 == 16'h0000);
    assign taken  = branch & (isZero == branchOnZero);

    always_comb begin
        if (halt) begin
            nextPc = pc;
        end else if (jumpReg) begin
            nextPc = aluOp1 + immediate;
        end else if (jump || taken) begin
            nextPc = pcPlus2 + immediate;
        end else begin
            nextPc = pcPlus2;
        end
    end

endmodule

`default_nettype wire

/* hw/decode.sv */
`default_nettype none

module decode (
    input  wire                clk,
    input  wire                rst,
    input  wire cpuPkg::instrT instr,
    input  wire  [15:0]        writeData,
    input  wire  [15:0]        pcPlus2,
    output logic [15:0]        aluOp1,
    output logic [15:0]        aluOp2,
    output logic [15:0]        immediate,
    output logic [15:0]        storeData,
    output logic               wbEn,
    output logic [2:0]         wbReg,
    output logic [15:0]        wbValue,
    output cpuPkg::aluOpT      aluOp,
    output logic               aluSrc,
    output logic               branch,
    output logic               branchOnZero,
    output logic               jump,
    output logic               jumpReg,
    output logic               memWrite,
    output logic               memRead,
    output logic               memToReg,
    output logic               halt,
    output logic               err
);
    import cpuPkg::*;

    immKindT     immKind;
    logic        regWrite;
    logic        iDest;
    logic        rDest;
    logic        link;
    logic        slbi;
    logic        lbi;
    logic [15:0] rsData;
    logic [15:0] rtData;

    controlUnit controlUnit_i (
        .instr        (instr),
        .aluOp        (aluOp),
        .immKind      (immKind),
        .aluSrc       (aluSrc),
        .regWrite     (regWrite),
        .iDest        (iDest),
        .rDest        (rDest),
        .link         (link),
        .branch       (branch),
        .branchOnZero (branchOnZero),
        .jump         (jump),
        .jumpReg      (jumpReg),
        .memWrite     (memWrite),
        .memRead      (memRead),
        .memToReg     (memToReg),
        .slbi         (slbi),
        .lbi          (lbi),
        .halt         (halt),
        .err          (err)
    );

    // lbi and slbi write back into rs
    always_comb begin
        if (link) begin
            wbReg = LinkReg;
        end else if (rDest) begin
            wbReg = instr.r.rd;
        end else if (iDest) begin
            wbReg = instr.i.rd;
        end else begin
            wbReg = instr.i.rs;
        end
    end

    always_comb begin
        case (immKind)
            immZero5: immediate = {11'b0, instr.i.imm5};
            immSign5: immediate = {{11{instr.i.imm5[4]}}, instr.i.imm5};
            immSign8: immediate = slbi ? {8'b0, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
            default:  immediate = {{5{instr[10]}}, instr[10:0]};
        endcase
    end

    assign wbEn    = regWrite & ~halt;
    assign wbValue = link ? pcPlus2 : writeData;

    regFile regFile_i (
        .clk     (clk),
        .rst     (rst),
        .rdSel1  (instr.i.rs),
        .rdSel2  (instr.i.rd),
        .wrSel   (wbReg),
        .wrEn    (wbEn),
        .wrData  (wbValue),
        .rdData1 (rsData),
        .rdData2 (rtData)
    );

    // slbi shifts the old value up so the add can merge the low byte
    assign aluOp1    = lbi ? 16'h0000 : (slbi ? {rsData[7:0], 8'h00} : rsData);
    assign aluOp2    = rtData;
    assign storeData = rtData;

endmodule

`default_nettype wire

/* hw/regFile.sv */
`default_nettype none

module regFile (
    input  wire         clk,
    input  wire         rst,
    input  wire  [2:0]  rdSel1,
    input  wire  [2:0]  rdSel2,
    input  wire  [2:0]  wrSel,
    input  wire         wrEn,
    input  wire  [15:0] wrData,
    output logic [15:0] rdData1,
    output logic [15:0] rdData2
);

    logic [15:0] regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrSel] <= wrData;
        end
    end

    // reads have no bypass so a write shows up on the next cycle
    assign rdData1 = regs[rdSel1];
    assign rdData2 = regs[rdSel2];

endmodule

`default_nettype wire

/* hw/controlUnit.sv */
`default_nettype none

module controlUnit (
    input  wire cpuPkg::instrT instr,
    output cpuPkg::aluOpT      aluOp,
    output cpuPkg::immKindT    immKind,
    output logic               aluSrc,
    output logic               regWrite,
    output logic               iDest,
    output logic               rDest,
    output logic               link,
    output logic               branch,
    output logic               branchOnZero,
    output logic               jump,
    output logic               jumpReg,
    output logic               memWrite,
    output logic               memRead,
    output logic               memToReg,
    output logic               slbi,
    output logic               lbi,
    output logic               halt,
    output logic               err
);
    import cpuPkg::*;

    always_comb begin
        // everything idle unless the opcode says otherwise
        aluOp        = aluPassB;
        immKind      = immSign5;
        aluSrc       = 1'b0;
        regWrite     = 1'b0;
        iDest        = 1'b0;
        rDest        = 1'b0;
        link         = 1'b0;
        branch       = 1'b0;
        branchOnZero = 1'b0;
        jump         = 1'b0;
        jumpReg      = 1'b0;
        memWrite     = 1'b0;
        memRead      = 1'b0;
        memToReg     = 1'b0;
        slbi         = 1'b0;
        lbi          = 1'b0;
        halt         = 1'b0;
        err          = 1'b0;

        case (instr.i.opcode)
            opHalt: begin
                halt = 1'b1;
            end
            opNop: begin
            end
            opAddi, opSubi, opXori, opAndni: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                iDest    = 1'b1;
                case (instr.i.opcode)
                    opAddi:  aluOp = aluAdd;
                    opSubi:  aluOp = aluSub;
                    opXori:  aluOp = aluXor;
                    default: aluOp = aluAndn;
                endcase
                // logic ops take the immediate zero-extended
                if (instr.i.opcode == opXori || instr.i.opcode == opAndni) begin
                    immKind = immZero5;
                end
            end
            opBeqz, opBnez: begin
                branch       = 1'b1;
                branchOnZero = (instr.i.opcode == opBeqz);
                immKind      = immSign8;
            end
            opSt: begin
                aluOp    = aluAdd;
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            opLd: begin
                aluOp    = aluAdd;
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
                iDest    = 1'b1;
            end
            opLbi, opSlbi: begin
                aluOp    = aluAdd;
                aluSrc   = 1'b1;
                immKind  = immSign8;
                regWrite = 1'b1;
                lbi      = (instr.i.opcode == opLbi);
                slbi     = (instr.i.opcode == opSlbi);
            end
            opAlu: begin
                regWrite = 1'b1;
                rDest    = 1'b1;
                case (instr.r.func)
                    2'b00:   aluOp = aluAdd;
                    2'b01:   aluOp = aluSub;
                    2'b10:   aluOp = aluXor;
                    default: aluOp = aluAndn;
                endcase
            end
            opSeq, opSlt: begin
                aluOp    = (instr.i.opcode == opSeq) ? aluSeq : aluSlt;
                regWrite = 1'b1;
                rDest    = 1'b1;
            end
            opJ, opJal: begin
                jump     = 1'b1;
                immKind  = immSign11;
                link     = (instr.i.opcode == opJal);
                regWrite = (instr.i.opcode == opJal);
            end
            opJr: begin
                jumpReg = 1'b1;
                immKind = immSign8;
            end
            default: begin
                err      = 1'b1;
                regWrite = 1'b0;
                memWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opJ     = 5'b00100,
        opJr    = 5'b00101,
        opJal   = 5'b00110,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opAndni = 5'b01011,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opSlbi  = 5'b10010,
        opLbi   = 5'b11000,
        opAlu   = 5'b11011,
        opSeq   = 5'b11100,
        opSlt   = 5'b11101
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluXor   = 3'd2,
        aluAndn  = 3'd3,
        aluPassB = 3'd4,
        aluSeq   = 3'd5,
        aluSlt   = 3'd6
    } aluOpT;

    // imm8 kind also covers slbi, which takes the byte unextended
    typedef enum logic [1:0] {
        immZero5  = 2'd0,
        immSign5  = 2'd1,
        immSign8  = 2'd2,
        immSign11 = 2'd3
    } immKindT;

    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm5;
    } iFormT;

    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] func;
    } rFormT;

    typedef union packed {
        iFormT i;
        rFormT r;
    } instrT;

    localparam logic [2:0] LinkReg = 3'd7;

endpackage

`default_nettype wire
